// ==== src/cp0_cfg.svh ====
`ifndef CP0_CFG_SVH
`define CP0_CFG_SVH

////////////////////
// cp0 register addresses (rd field)
`define CP0_REG_COUNT    5'd9
`define CP0_REG_STATUS   5'd12
`define CP0_REG_CAUSE    5'd13
`define CP0_REG_EPC      5'd14

////////////////////
// status after reset, all int masks open, ie set
`define CP0_STATUS_RESET 32'h0000_ff01

// common trap entry point
`define CP0_EXC_VECTOR   32'h0000_0380

// exc codes, land in cause[6:2]
`define CP0_EXC_INT      5'd0
`define CP0_EXC_SYS      5'd8

`endif

// ==== src/cp0_pkg.sv ====
package cp0_pkg;

    ////////////////////
    // decoded instruction kinds
    typedef enum logic [2:0] {
        OP_NONE,     // not a cp0 instruction
        OP_MFC0,
        OP_MTC0,
        OP_SYSCALL,
        OP_ERET
    } cp0_op_e;

    // what the register stage decided this cycle
    typedef enum logic [1:0] {
        TRAP_NONE,
        TRAP_SYSCALL,
        TRAP_INTR,
        TRAP_ERET
    } cp0_trap_e;

    ////////////////////
    typedef struct packed {
        logic        valid;
        cp0_op_e     op;
        logic [4:0]  addr;   // rd field, cp0 reg number
        logic [31:0] wdata;  // rt value for mtc0
        logic [31:0] pc;     // pc of the instruction itself
    } cp0_req_t;

    typedef struct packed {
        logic [31:0] status;
        logic [31:0] cause;
        logic [31:0] epc;
        logic [31:0] count;
    } cp0_state_t;

    // target is the saved pc on entry, the return pc on eret
    typedef struct packed {
        cp0_trap_e   kind;
        logic [31:0] target;
    } cp0_event_t;

endpackage

// ==== src/cp0_decode.sv ====
`timescale 1ns/1ps

module cp0_decode import cp0_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        instr_valid,  // one-cycle strobe
    input  logic [31:0] instr,
    input  logic [31:0] instr_pc,
    input  logic [31:0] rt_data,
    output cp0_req_t    req
);

    ////////////////////
    // instruction fields
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rd;
    logic [5:0] funct;
    logic       co;    // bit 25, coprocessor op form

    cp0_op_e op_dec;

    assign opcode = instr[31:26];
    assign rs     = instr[25:21];
    assign rd     = instr[15:11];
    assign funct  = instr[5:0];
    assign co     = instr[25];

    ////////////////////
    // opcode match
    always_comb begin
        op_dec = OP_NONE;
        if (opcode == 6'b010000) begin           // COP0
            if (co && funct == 6'b011000)
                op_dec = OP_ERET;
            else if (rs == 5'b00000)
                op_dec = OP_MFC0;
            else if (rs == 5'b00100)
                op_dec = OP_MTC0;
        end else if (opcode == 6'b000000) begin  // SPECIAL
            if (funct == 6'b001100)
                op_dec = OP_SYSCALL;
        end
    end

    ////////////////////
    // request register, one cycle after the strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req.valid <= 1'b0;
            req.op    <= OP_NONE;
            req.addr  <= 5'd0;
            req.wdata <= 32'd0;
            req.pc    <= 32'd0;
        end else begin
            // non-cp0 words leave valid low
            req.valid <= instr_valid && (op_dec != OP_NONE);
            req.op    <= instr_valid ? op_dec : OP_NONE;
            req.addr  <= rd;          // only meaningful for mfc0/mtc0
            req.wdata <= rt_data;
            req.pc    <= instr_pc;
        end
    end

endmodule

// ==== src/cp0_regs.sv ====
`timescale 1ns/1ps
`include "cp0_cfg.svh"

module cp0_regs import cp0_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  cp0_req_t    req,
    input  logic [31:0] resume_pc,  // where to come back after an interrupt
    input  logic [7:0]  hw_intr,    // level inputs, sampled each cycle
    output cp0_state_t  state,
    output cp0_event_t  evt
);

    ////////////////////
    // request qualifiers
    logic is_mtc0;
    logic is_sys;
    logic is_eret;
    logic wr_cause;  // mtc0 to cause, beats interrupt sampling
    logic wr_count;

    assign is_mtc0  = req.valid && (req.op == OP_MTC0);
    assign is_sys   = req.valid && (req.op == OP_SYSCALL);
    assign is_eret  = req.valid && (req.op == OP_ERET);
    assign wr_cause = is_mtc0 && (req.addr == `CP0_REG_CAUSE);
    assign wr_count = is_mtc0 && (req.addr == `CP0_REG_COUNT);

    ////////////////////
    // interrupt test, the only place it is done
    logic       ie;
    logic [7:0] pend;
    logic       intr_take;

    assign ie   = state.status[0];
    assign pend = state.status[15:8] & state.cause[15:8];  // masked pending lines

    // only in an idle cycle, no nesting
    assign intr_take = !req.valid && ie && (|pend);

    ////////////////////
    // trap decision, same cycle as the request
    always_comb begin
        evt.kind   = TRAP_NONE;
        evt.target = state.epc;
        if (is_sys) begin
            // syscall with ie clear is dropped
            if (ie) begin
                evt.kind   = TRAP_SYSCALL;
                evt.target = req.pc;      // epc gets the syscall itself
            end
        end else if (is_eret) begin
            evt.kind   = TRAP_ERET;
            evt.target = state.epc;       // return to saved pc
        end else if (intr_take) begin
            evt.kind   = TRAP_INTR;
            evt.target = resume_pc;
        end
    end

    ////////////////////
    // architectural registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state.status <= `CP0_STATUS_RESET;
            state.cause  <= 32'd0;
            state.epc    <= 32'd0;
            state.count  <= 32'd0;
        end else begin
            // free running counter
            if (wr_count)
                state.count <= req.wdata;
            else
                state.count <= state.count + 32'd1;

            if (!wr_cause)
                state.cause[15:8] <= hw_intr;  // ip bits follow the lines

            // software writes
            if (is_mtc0) begin
                case (req.addr)
                    `CP0_REG_STATUS: state.status <= req.wdata;
                    `CP0_REG_CAUSE:  state.cause  <= req.wdata;
                    `CP0_REG_EPC:    state.epc    <= req.wdata;
                    default: ;                     // count above, rest unmapped
                endcase
            end

            // trap entry and exit
            case (evt.kind)
                TRAP_SYSCALL: begin
                    state.cause[6:2] <= `CP0_EXC_SYS;
                    state.status[0]  <= 1'b0;     // mask further ints
                    state.epc        <= evt.target;
                end
                TRAP_INTR: begin
                    state.cause[6:2] <= `CP0_EXC_INT;
                    state.status[0]  <= 1'b0;
                    state.epc        <= evt.target;
                end
                TRAP_ERET: begin
                    state.status[0] <= 1'b1;      // unmask again
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== src/cp0_commit.sv ====
`timescale 1ns/1ps
`include "cp0_cfg.svh"

module cp0_commit import cp0_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  cp0_req_t    req,
    input  cp0_state_t  state,
    input  cp0_event_t  evt,
    output logic        rd_valid,
    output logic [31:0] rd_data,
    output logic        redirect,     // one-cycle pulse
    output logic [31:0] redirect_pc
);

    ////////////////////
    // mfc0 read mux, pre-edge state
    logic [31:0] rd_mux;
    logic        is_mfc0;
    logic        take;
    logic [31:0] target;

    assign is_mfc0 = req.valid && (req.op == OP_MFC0);

    always_comb begin
        case (req.addr)
            `CP0_REG_STATUS: rd_mux = state.status;
            `CP0_REG_CAUSE:  rd_mux = state.cause;
            `CP0_REG_EPC:    rd_mux = state.epc;
            `CP0_REG_COUNT:  rd_mux = state.count;
            default:         rd_mux = 32'd0;  // unmapped reads zero
        endcase
    end

    ////////////////////
    // redirect target
    assign take   = (evt.kind != TRAP_NONE);
    // eret goes back to epc, everything else to the vector
    assign target = (evt.kind == TRAP_ERET) ? evt.target : `CP0_EXC_VECTOR;

    // strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
            redirect <= 1'b0;
        end else begin
            rd_valid <= is_mfc0;
            redirect <= take;
        end
    end

    // data, only looked at with its strobe
    always_ff @(posedge clk) begin
        if (is_mfc0)
            rd_data <= rd_mux;
        if (take)
            redirect_pc <= target;
    end

endmodule

// ==== src/cp0_unit.sv ====
`timescale 1ns/1ps

module cp0_unit import cp0_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    input  logic [31:0] instr_pc,
    input  logic [31:0] rt_data,
    input  logic [31:0] resume_pc,
    input  logic [7:0]  hw_intr,
    output logic        rd_valid,
    output logic [31:0] rd_data,
    output logic        redirect,
    output logic [31:0] redirect_pc
);

    ////////////////////
    cp0_req_t   req;    // decode -> regs, commit
    cp0_state_t state;  // regs -> commit
    cp0_event_t evt;    // trap decision

    cp0_decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .rt_data     (rt_data),
        .req         (req)
    );

    cp0_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .resume_pc (resume_pc),
        .hw_intr   (hw_intr),
        .state     (state),
        .evt       (evt)
    );

    cp0_commit u_commit (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .state       (state),
        .evt         (evt),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

endmodule

// ==== testbench/cp0_tb.sv ====
`timescale 1ns/1ps
`include "cp0_cfg.svh"

module cp0_tb;

    ////////////////////
    // expected outputs for one issue slot
    typedef struct packed {
        logic        rd_valid;
        logic        is_count;     // only deltas checked
        logic [31:0] rd_data;
        logic        redirect;
        logic [31:0] redirect_pc;
    } expect_t;

    localparam int CYCLE_LIMIT = 600;  // stimulus needs about 110 cycles

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] instr_pc;
    logic [31:0] rt_data;
    logic [31:0] resume_pc;
    logic [7:0]  hw_intr;
    logic        rd_valid;
    logic [31:0] rd_data;
    logic        redirect;
    logic [31:0] redirect_pc;

    expect_t nxt;      // driven together with the strobe
    expect_t exp_d1;
    expect_t exp_q;    // lines up with the dut outputs

    // reference copy of the architectural registers
    logic [31:0] m_status;
    logic [31:0] m_cause;   // bits 15:8 follow hw_intr instead
    logic [31:0] m_epc;

    int assert_errors = 0;  // from the concurrent checks
    int seq_errors    = 0;  // from checks in the sequence
    int cycles        = 0;
    int redirects     = 0;
    int exp_redirects = 0;
    int reads         = 0;
    logic [31:0] count_reads[$];

    cp0_unit UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .rt_data     (rt_data),
        .resume_pc   (resume_pc),
        .hw_intr     (hw_intr),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    ////////////////////
    // two-stage delay so the expectation meets the dut result
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_d1 <= '0;
            exp_q  <= '0;
        end else begin
            exp_d1 <= nxt;
            exp_q  <= exp_d1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: test did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Verification failed");
            $finish;
        end
    end

    // collect count reads and redirect pulses at mid-cycle
    always @(negedge clk) begin
        if (rst_n && rd_valid && exp_q.is_count)
            count_reads.push_back(rd_data);
        if (rst_n && redirect)
            redirects++;
    end

    ////////////////////
    // output checks at every falling edge
    rd_valid_chk: assert property (@(negedge clk) disable iff (!rst_n)
        rd_valid == exp_q.rd_valid)
    else begin
        assert_errors++;
        $display("Fail %0t rd_valid expected %b got %b", $time, exp_q.rd_valid, rd_valid);
    end

    rd_data_chk: assert property (@(negedge clk) disable iff (!rst_n)
        (exp_q.rd_valid && !exp_q.is_count) |-> rd_data == exp_q.rd_data)
    else begin
        assert_errors++;
        $display("Fail %0t rd_data expected %h got %h", $time, exp_q.rd_data, rd_data);
    end

    redirect_chk: assert property (@(negedge clk) disable iff (!rst_n)
        redirect == exp_q.redirect)
    else begin
        assert_errors++;
        $display("Fail %0t redirect expected %b got %b", $time, exp_q.redirect, redirect);
    end

    redirect_pc_chk: assert property (@(negedge clk) disable iff (!rst_n)
        exp_q.redirect |-> redirect_pc == exp_q.redirect_pc)
    else begin
        assert_errors++;
        $display("Fail %0t redirect_pc expected %h got %h", $time,
                 exp_q.redirect_pc, redirect_pc);
    end

    ////////////////////
    // cause as a read would see it with ip bits from the lines
    function automatic logic [31:0] cause_now();
        return {m_cause[31:16], hw_intr, m_cause[7:0]};
    endfunction

    // one strobe from 1 ns after a rising edge to 1 ns after the next
    task automatic send_word(input logic [31:0] word, input logic [31:0] pc,
                             input logic [31:0] rt, input expect_t e);
        instr_valid = 1'b1;
        instr       = word;
        instr_pc    = pc;
        rt_data     = rt;
        nxt         = e;
        if (e.redirect)
            exp_redirects++;
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        nxt         = '0;
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic issue_mtc0(input logic [4:0] addr, input logic [31:0] data);
        case (addr)
            `CP0_REG_STATUS: m_status = data;
            `CP0_REG_CAUSE:  m_cause  = data;
            `CP0_REG_EPC:    m_epc    = data;
            default: ;                        // count and unmapped not modeled
        endcase
        send_word({6'b010000, 5'b00100, 5'd2, addr, 11'd0}, 32'h0040_0000, data, '0);
    endtask

    task automatic issue_mfc0(input logic [4:0] addr);
        expect_t e;
        e          = '0;
        e.rd_valid = 1'b1;
        case (addr)
            `CP0_REG_STATUS: e.rd_data  = m_status;
            `CP0_REG_CAUSE:  e.rd_data  = cause_now();
            `CP0_REG_EPC:    e.rd_data  = m_epc;
            `CP0_REG_COUNT:  e.is_count = 1'b1;
            default:         e.rd_data  = 32'd0;  // unmapped
        endcase
        reads++;
        send_word({6'b010000, 5'b00000, 5'd3, addr, 11'd0}, 32'h0040_0004, 32'd0, e);
    endtask

    task automatic issue_syscall(input logic [31:0] pc);
        expect_t e;
        e = '0;
        if (m_status[0]) begin          // dropped while ie is clear
            e.redirect    = 1'b1;
            e.redirect_pc = `CP0_EXC_VECTOR;
            m_epc         = pc;
            m_cause[6:2]  = `CP0_EXC_SYS;
            m_status[0]   = 1'b0;
        end
        send_word({6'b000000, 20'd0, 6'b001100}, pc, 32'd0, e);
    endtask

    task automatic issue_eret();
        expect_t e;
        e             = '0;
        e.redirect    = 1'b1;
        e.redirect_pc = m_epc;          // back to the saved pc
        m_status[0]   = 1'b1;
        send_word({6'b010000, 1'b1, 19'd0, 6'b011000}, 32'h0040_0008, 32'd0, e);
    endtask

    // raise one line with no strobe so the regs stage sees an idle slot
    task automatic raise_irq(input int irq_line, input logic [31:0] pc);
        expect_t e;
        e = '0;
        if (m_status[0] && m_status[8 + irq_line]) begin
            e.redirect    = 1'b1;
            e.redirect_pc = `CP0_EXC_VECTOR;
            m_epc         = pc;
            m_cause[6:2]  = `CP0_EXC_INT;
            m_status[0]   = 1'b0;
            exp_redirects++;
        end
        resume_pc = pc;
        hw_intr   = 8'd1 << irq_line;
        nxt       = e;
        @(posedge clk);
        #1;
        nxt = '0;
    endtask

    task automatic drop_irq();
        hw_intr = 8'd0;
        idle(2);                        // let cause ip bits clear
    endtask

    // two count reads issued k cycles apart
    task automatic check_count_gap(input int k);
        logic [31:0] first;
        logic [31:0] second;
        issue_mfc0(`CP0_REG_COUNT);
        if (k > 1)
            idle(k - 1);
        issue_mfc0(`CP0_REG_COUNT);
        idle(2);
        if (count_reads.size() < 2) begin
            seq_errors++;
            $display("count reads did not arrive at %0t", $time);
        end else begin
            first  = count_reads.pop_front();
            second = count_reads.pop_front();
            count_delta_chk: assert (second - first == k)
            else begin
                seq_errors++;
                $display("Fail %0t count delta expected %0d got %0d", $time, k, second - first);
            end
        end
    endtask

    ////////////////////
    // main sequence
    initial begin
        logic [31:0] data;
        int          irq_line;
        void'($urandom(58088));
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = 32'd0;
        instr_pc    = 32'd0;
        rt_data     = 32'd0;
        resume_pc   = 32'd0;
        hw_intr     = 8'd0;
        nxt         = '0;
        m_status    = `CP0_STATUS_RESET;
        m_cause     = 32'd0;
        m_epc       = 32'd0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        idle(3);

        // reset values with outputs quiet until now
        issue_mfc0(`CP0_REG_STATUS);
        issue_mfc0(`CP0_REG_CAUSE);
        issue_mfc0(`CP0_REG_EPC);
        send_word(32'h0109_5020, 32'h0040_0100, 32'd0, '0);  // add is no cp0 word
        idle(2);

        // write then read back
        repeat (4) begin
            data = $urandom;
            issue_mtc0(`CP0_REG_STATUS, data);
            issue_mfc0(`CP0_REG_STATUS);
            data = $urandom & 32'hffff_00ff;  // ip bits zero so no stray interrupt
            issue_mtc0(`CP0_REG_CAUSE, data);
            issue_mfc0(`CP0_REG_CAUSE);
            data = $urandom;
            issue_mtc0(`CP0_REG_EPC, data);
            issue_mfc0(`CP0_REG_EPC);
        end
        issue_mfc0(5'd3);
        issue_mfc0(5'd31);
        issue_mtc0(`CP0_REG_STATUS, `CP0_STATUS_RESET);
        idle(2);

        // free running count
        check_count_gap(1);
        check_count_gap(2 + ($urandom % 6));

        // syscall taken then dropped with ie clear
        issue_syscall(32'h0040_0200);
        issue_mfc0(`CP0_REG_EPC);
        issue_mfc0(`CP0_REG_CAUSE);
        issue_mfc0(`CP0_REG_STATUS);
        issue_syscall(32'h0040_0300);
        idle(3);

        // eret back to the syscall pc
        issue_eret();
        issue_mfc0(`CP0_REG_STATUS);
        idle(2);

        // interrupt on an open mask line
        irq_line = $urandom % 8;
        raise_irq(irq_line, 32'h0040_0400 + (($urandom % 64) << 2));
        idle(2);
        issue_mfc0(`CP0_REG_EPC);
        issue_mfc0(`CP0_REG_CAUSE);
        issue_mfc0(`CP0_REG_STATUS);
        drop_irq();
        issue_eret();
        idle(2);

        // a random line with its mask bit closed
        irq_line = $urandom % 8;
        issue_mtc0(`CP0_REG_STATUS, `CP0_STATUS_RESET & ~(32'h100 << irq_line));
        idle(1);
        raise_irq(irq_line, 32'h0040_0500);
        idle(4);
        issue_mfc0(`CP0_REG_CAUSE);           // pending but masked
        drop_irq();
        issue_mtc0(`CP0_REG_STATUS, `CP0_STATUS_RESET);
        idle(4);

        redirect_count_chk: assert (redirects == exp_redirects)
        else begin
            seq_errors++;
            $display("wrong number of redirect pulses, %0d seen and %0d expected",
                     redirects, exp_redirects);
        end

        $display("summary: %0d reads, %0d redirects, %0d assertion errors, %0d sequence errors",
                 reads, redirects, assert_errors, seq_errors);
        if (assert_errors == 0 && seq_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+src
src/cp0_pkg.sv
src/cp0_decode.sv
src/cp0_regs.sv
src/cp0_commit.sv
src/cp0_unit.sv
testbench/cp0_tb.sv

// ==== Makefile ====
# verilator build and run of the cp0 testbench
TOP = cp0_tb
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): list.f $(wildcard src/*.sv src/*.svh testbench/*.sv)
	verilator --binary --timing --assert -j 0 -f list.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Verification passed" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	verilator --lint-only --timing -f list.f --top-module cp0_unit

clean:
	rm -rf obj_dir $(LOG)
